// ==== Bender.yml ====
package:
  name: weight_buffer

sources:
  - files:
      - common/conv_pkg.sv
      - weight_buffer/weight_shift_chain.sv
      - weight_buffer/tap_counter.sv
      - weight_buffer/weight_load_fsm.sv
      - src/kernel_fifo.sv
      - src/conv_window_mac.sv
      - src/weight_buffer_top.sv
  - target: test
    files:
      - bench/weight_buffer_checker.sv
      - bench/weight_buffer_tb.sv

// ==== bench/weight_buffer_checker.sv ====
`timescale 1ns/10ps

module weight_buffer_checker #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   run_done,
	input  conv_pkg::weight_beat_t weight_in,
	input  logic                   weight_credit,
	input  logic                   load_weights,
	input  conv_pkg::window_t      window_in,
	input  logic                   window_valid,
	input  logic                   kernel_valid,
	input  conv_pkg::kernel_t      active_kernel,
	input  conv_pkg::conv_result_t result,
	output int                     errors
);

	localparam int TAPS = conv_pkg::KERNEL_TAPS;

	conv_pkg::kernel_t kq [$];
	conv_pkg::window_t wq [$];
	conv_pkg::kernel_t partial;
	conv_pkg::kernel_t model_active;
	conv_pkg::kernel_t stage1_k;
	conv_pkg::kernel_t stage2_k;
	logic              stage1_v;
	logic              stage2_v;
	logic              model_kv;
	logic              done_seen;
	int                taps_seen;
	int                credits_due;
	int                sender_credits;

	// Signed 3x3 dot product from the window and kernel words
	function automatic conv_pkg::acc_t expected_dot(input conv_pkg::window_t win,
			input conv_pkg::kernel_t kern);
		conv_pkg::acc_t acc;
		logic signed [31:0] prod;
		acc = '0;
		for (int i = 0; i < TAPS; i++) begin
			prod = win.pixel[i] * kern.tap[i];
			acc = acc + prod;
		end
		return acc;
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			kq.delete();
			wq.delete();
			taps_seen = 0;
			credits_due = KERNEL_DEPTH * TAPS;
			sender_credits = 0;
			stage1_v = 1'b0;
			stage2_v = 1'b0;
			model_kv = 1'b0;
			model_active = '0;
			done_seen = 1'b0;
			errors = 0;
		end else begin
			////////////////////////////////////////////////////////////
			// Credits
			if (weight_credit) begin
				if (credits_due == 0) begin
					$display("credit pulse arrived when no credit was owed");
					errors++;
				end else begin
					credits_due--;
				end
				sender_credits++;
			end
			// Beats assemble into kernels, tap 0 first
			if (weight_in.valid) begin
				if (sender_credits == 0) begin
					$display("weight beat sent without a credit");
					errors++;
				end else begin
					sender_credits--;
				end
				partial.tap[taps_seen] = weight_in.data;
				taps_seen++;
				if (taps_seen == TAPS) begin
					kq.push_back(partial);
					taps_seen = 0;
				end
			end
			////////////////////////////////////////////////////////////
			// Results, against the kernel held while the window was popped
			if (result.valid) begin
				if (!model_kv || wq.size() == 0) begin
					$display("result appeared with no loaded kernel or no queued window");
					errors++;
				end else if (result.sum !== expected_dot(wq[0], model_active)) begin
					$display("FAILED result.sum: got %h expected %h",
						result.sum, expected_dot(wq[0], model_active));
					errors++;
					void'(wq.pop_front());
				end else begin
					void'(wq.pop_front());
				end
			end
			////////////////////////////////////////////////////////////
			// Kernel load, visible two cycles later
			if (stage2_v) begin
				model_active = stage2_k;
				model_kv = 1'b1;
			end
			stage2_v = stage1_v;
			stage2_k = stage1_k;
			stage1_v = 1'b0;
			if (load_weights && kq.size() > 0) begin
				stage1_k = kq.pop_front();
				stage1_v = 1'b1;
				credits_due += TAPS;
			end
			if (kernel_valid !== model_kv) begin
				$display("FAILED kernel_valid: got %h expected %h", kernel_valid, model_kv);
				errors++;
			end
			if (model_kv && active_kernel !== model_active) begin
				$display("FAILED active_kernel: got %h expected %h",
					active_kernel, model_active);
				errors++;
			end
			////////////////////////////////////////////////////////////
			// Windows
			if (window_valid) begin
				wq.push_back(window_in);
			end
			if (run_done && !done_seen) begin
				done_seen = 1'b1;
				if (wq.size() != 0) begin
					$display("%0d windows never produced a result", wq.size());
					errors++;
				end
				if (credits_due != 0) begin
					$display("%0d credits were never returned", credits_due);
					errors++;
				end
			end
		end
	end

endmodule

// ==== bench/weight_buffer_tb.sv ====
`timescale 1ns/10ps

module weight_buffer_tb;

	localparam int KERNEL_DEPTH = 4;
	localparam int WINDOW_DEPTH = 8;
	localparam int TAPS         = conv_pkg::KERNEL_TAPS;
	localparam int TABLE_LEN    = 19;
	localparam int CYCLE_LIMIT  = TABLE_LEN * 40 + 200;

	// Step kinds
	localparam int WIN   = 0;
	localparam int KER   = 1;
	localparam int LOAD  = 2;
	localparam int DLOAD = 3;

	typedef struct packed {
		logic [1:0]                    kind;
		conv_pkg::word_t [TAPS-1:0]    data;
	} step_t;

	logic                   clk;
	logic                   reset;
	conv_pkg::weight_beat_t weight_in;
	logic                   weight_credit;
	logic                   load_weights;
	conv_pkg::window_t      window_in;
	logic                   window_valid;
	logic                   kernel_valid;
	conv_pkg::kernel_t      active_kernel;
	conv_pkg::conv_result_t result;
	logic                   run_done;
	int                     check_errors;
	int                     credits;
	int                     cycle_count;
	step_t                  steps [TABLE_LEN];
	int                     kinds [TABLE_LEN] = '{WIN, WIN, KER, KER, KER, KER, LOAD, KER,
		WIN, LOAD, WIN, DLOAD, WIN, LOAD, LOAD, WIN, KER, LOAD, WIN};

	weight_buffer_top #(
		.KERNEL_DEPTH(KERNEL_DEPTH),
		.WINDOW_DEPTH(WINDOW_DEPTH)
	) u_weight_buffer_top (
		.clk          (clk),
		.reset        (reset),
		.weight_in    (weight_in),
		.weight_credit(weight_credit),
		.load_weights (load_weights),
		.window_in    (window_in),
		.window_valid (window_valid),
		.kernel_valid (kernel_valid),
		.active_kernel(active_kernel),
		.result       (result)
	);

	weight_buffer_checker #(
		.KERNEL_DEPTH(KERNEL_DEPTH)
	) u_checker (
		.clk(clk), .reset(reset), .run_done(run_done),
		.weight_in(weight_in), .weight_credit(weight_credit),
		.load_weights(load_weights), .window_in(window_in),
		.window_valid(window_valid), .kernel_valid(kernel_valid),
		.active_kernel(active_kernel), .result(result), .errors(check_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("errors: %0d", check_errors + 1);
			$display("tests failed");
			$finish;
		end
	end

	// One clock, counting credits and clearing one-cycle inputs
	task automatic tick();
		@(posedge clk);
		if (weight_credit) begin
			credits++;
		end
		weight_in    <= '0;
		load_weights <= 1'b0;
		window_valid <= 1'b0;
	endtask

	task automatic send_weight(input conv_pkg::word_t w);
		repeat ($urandom % 3) tick();
		tick();
		while (credits == 0) begin
			tick();
		end
		weight_in <= '{valid: 1'b1, data: w};
		credits--;
	endtask

	initial begin
		void'($urandom(32'hc4f28a7c));
		cycle_count = 0;
		credits = 0;
		reset = 1'b1;
		weight_in = '0;
		load_weights = 1'b0;
		window_in = '0;
		window_valid = 1'b0;
		run_done = 1'b0;
		// Mixed-sign words that depend on step and tap
		for (int s = 0; s < TABLE_LEN; s++) begin
			steps[s].kind = kinds[s][1:0];
			for (int t = 0; t < TAPS; t++) begin
				steps[s].data[t] = conv_pkg::word_t'(s * 4099 + t * 9173 - 30000);
			end
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// Whole initial grant before the first beat
		while (credits < KERNEL_DEPTH * TAPS) begin
			tick();
		end
		for (int s = 0; s < TABLE_LEN; s++) begin
			case (steps[s].kind)
				KER: begin
					for (int t = 0; t < TAPS; t++) begin
						send_weight(steps[s].data[t]);
					end
				end
				LOAD: begin
					tick();
					load_weights <= 1'b1;
				end
				DLOAD: begin
					tick();
					load_weights <= 1'b1;
					tick();
					load_weights <= 1'b1;
				end
				default: begin
					tick();
					window_in.pixel <= steps[s].data;
					window_valid <= 1'b1;
				end
			endcase
			repeat (6) tick();
		end
		repeat (40) tick();
		run_done <= 1'b1;
		repeat (3) tick();
		@(negedge clk);
		$display("errors: %0d", check_errors);
		if (check_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== common/conv_pkg.sv ====
package conv_pkg;

	////////////////////////////////////////////////////////////
	// Sizes

	// 3x3 kernel
	localparam int KERNEL_TAPS = 9;
	localparam int WORD_WIDTH  = 16;
	// Nine 32-bit products need four guard bits
	localparam int ACC_WIDTH   = 36;

	////////////////////////////////////////////////////////////
	// Types

	typedef logic signed [WORD_WIDTH-1:0] word_t;
	typedef logic signed [ACC_WIDTH-1:0]  acc_t;

	// One weight per cycle from upstream
	typedef struct packed {
		logic  valid;
		word_t data;
	} weight_beat_t;

	// Tap 0 is the first weight received
	typedef struct packed {
		word_t [KERNEL_TAPS-1:0] tap;
	} kernel_t;

	// Same tap order as the kernel
	typedef struct packed {
		word_t [KERNEL_TAPS-1:0] pixel;
	} window_t;

	typedef struct packed {
		logic valid;
		acc_t sum;
	} conv_result_t;

endpackage

// ==== sources.f ====
common/conv_pkg.sv
weight_buffer/weight_shift_chain.sv
weight_buffer/tap_counter.sv
weight_buffer/weight_load_fsm.sv
src/kernel_fifo.sv
src/conv_window_mac.sv
src/weight_buffer_top.sv
bench/weight_buffer_checker.sv
bench/weight_buffer_tb.sv

// ==== src/conv_window_mac.sv ====
`timescale 1ns/10ps

module conv_window_mac (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   kernel_load,
	input  conv_pkg::kernel_t      kernel_rdata,
	input  logic                   window_empty,
	input  conv_pkg::window_t      window_rdata,
	output logic                   window_pop,
	output logic                   kernel_valid,
	output conv_pkg::kernel_t      active_kernel,
	output conv_pkg::conv_result_t result
);

	logic           window_ready;
	logic           result_valid;
	conv_pkg::acc_t result_sum;
	conv_pkg::acc_t dot;

	// No pop while a new kernel lands, so each window sees one kernel
	assign window_pop = !window_empty && kernel_valid && !kernel_load;

	// Signed 3x3 dot product
	always_comb begin
		dot = '0;
		for (int i = 0; i < conv_pkg::KERNEL_TAPS; i++) begin
			dot = dot + window_rdata.pixel[i] * active_kernel.tap[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_valid <= 1'b0;
			window_ready <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			window_ready <= window_pop;
			result_valid <= window_ready;
			// Stays set once the first kernel is in
			if (kernel_load) begin
				kernel_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (kernel_load) begin
			active_kernel <= kernel_rdata;
		end
		if (window_ready) begin
			result_sum <= dot;
		end
	end

	assign result.valid = result_valid;
	assign result.sum   = result_sum;

endmodule

// ==== src/kernel_fifo.sv ====
`timescale 1ns/10ps

module kernel_fifo #(
	parameter type payload_t = conv_pkg::kernel_t,
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  payload_t wdata,
	input  logic     pop,
	output payload_t rdata,
	output logic     empty,
	output logic     full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// Depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty   = (count == '0);
	assign full    = (count == CNT_W'(DEPTH));
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
		end
	end

	// Storage and read register
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata;
		end
		if (do_pop) begin
			rdata <= mem[rd_ptr];
		end
	end

endmodule

// ==== src/weight_buffer_top.sv ====
`timescale 1ns/10ps

module weight_buffer_top #(
	parameter int KERNEL_DEPTH = 4,
	parameter int WINDOW_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  conv_pkg::weight_beat_t weight_in,
	output logic                   weight_credit,
	input  logic                   load_weights,
	input  conv_pkg::window_t      window_in,
	input  logic                   window_valid,
	output logic                   kernel_valid,
	output conv_pkg::kernel_t      active_kernel,
	output conv_pkg::conv_result_t result
);

	conv_pkg::kernel_t chain_kernel;
	conv_pkg::kernel_t kernel_wdata;
	conv_pkg::kernel_t kernel_rdata;
	conv_pkg::window_t window_rdata;
	logic              kernel_push;
	logic              kernel_pop;
	logic              kernel_empty;
	logic              kernel_load;
	logic              window_pop;
	logic              window_empty;

	////////////////////////////////////////////////////////////
	// Weight path

	weight_shift_chain u_chain (
		.clk   (clk),
		.reset (reset),
		.beat  (weight_in),
		.kernel(chain_kernel)
	);

	weight_load_fsm #(
		.KERNEL_DEPTH(KERNEL_DEPTH)
	) u_fsm (
		.clk          (clk),
		.reset        (reset),
		.beat         (weight_in),
		.kernel       (chain_kernel),
		.kernel_pop   (kernel_pop),
		.kernel_push  (kernel_push),
		.kernel_wdata (kernel_wdata),
		.weight_credit(weight_credit)
	);

	// Load requests on an empty queue are ignored
	assign kernel_pop = load_weights && !kernel_empty;

	kernel_fifo #(
		.payload_t(conv_pkg::kernel_t),
		.DEPTH    (KERNEL_DEPTH)
	) u_kernel_q (
		.clk  (clk),
		.reset(reset),
		.push (kernel_push),
		.wdata(kernel_wdata),
		.pop  (kernel_pop),
		.rdata(kernel_rdata),
		.empty(kernel_empty),
		.full ()
	);

	// Popped kernel is on rdata one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel_load <= 1'b0;
		end else begin
			kernel_load <= kernel_pop;
		end
	end

	////////////////////////////////////////////////////////////
	// Window path

	kernel_fifo #(
		.payload_t(conv_pkg::window_t),
		.DEPTH    (WINDOW_DEPTH)
	) u_window_q (
		.clk  (clk),
		.reset(reset),
		.push (window_valid),
		.wdata(window_in),
		.pop  (window_pop),
		.rdata(window_rdata),
		.empty(window_empty),
		.full ()
	);

	conv_window_mac u_mac (
		.clk          (clk),
		.reset        (reset),
		.kernel_load  (kernel_load),
		.kernel_rdata (kernel_rdata),
		.window_empty (window_empty),
		.window_rdata (window_rdata),
		.window_pop   (window_pop),
		.kernel_valid (kernel_valid),
		.active_kernel(active_kernel),
		.result       (result)
	);

endmodule

// ==== weight_buffer/tap_counter.sv ====
`timescale 1ns/10ps

module tap_counter #(
	parameter int COUNT_MAX = 8
) (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           step,
	output logic [$clog2(COUNT_MAX+1)-1:0] count,
	output logic                           wrap
);

	localparam int COUNT_W = $clog2(COUNT_MAX + 1);

	// Pulses with the step that takes the count back to zero
	assign wrap = step && (count == COUNT_W'(COUNT_MAX));

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (wrap) begin
			count <= '0;
		end else if (step) begin
			count <= count + 1'b1;
		end
	end

endmodule

// ==== weight_buffer/weight_load_fsm.sv ====
`timescale 1ns/10ps

module weight_load_fsm #(
	parameter int KERNEL_DEPTH = 4
) (
	input  logic                   clk,
	input  logic                   reset,
	input  conv_pkg::weight_beat_t beat,
	input  conv_pkg::kernel_t      kernel,
	input  logic                   kernel_pop,
	output logic                   kernel_push,
	output conv_pkg::kernel_t      kernel_wdata,
	output logic                   weight_credit
);

	localparam int TAPS  = conv_pkg::KERNEL_TAPS;
	localparam int SET_W = $clog2(KERNEL_DEPTH + 1);

	typedef enum logic [1:0] {
		GRANT,
		RUN,
		RETURN
	} state_t;

	state_t           state;
	state_t           state_next;
	logic [SET_W-1:0] grant_sets;
	logic [SET_W-1:0] pending;
	logic [SET_W-1:0] pending_next;
	logic             tap_wrap;
	logic             credit_wrap;
	logic             set_done;

	// Ninth accepted weight
	tap_counter #(
		.COUNT_MAX(TAPS - 1)
	) u_tap_count (
		.clk  (clk),
		.reset(reset),
		.step (beat.valid),
		.count(),
		.wrap (tap_wrap)
	);

	// Ninth credit of a set
	tap_counter #(
		.COUNT_MAX(TAPS - 1)
	) u_credit_count (
		.clk  (clk),
		.reset(reset),
		.step (weight_credit),
		.count(),
		.wrap (credit_wrap)
	);

	////////////////////////////////////////////////////////////
	// Credit sequencing

	assign set_done     = (state == RETURN) && credit_wrap;
	// Pops during GRANT are kept and returned afterwards
	assign pending_next = pending + SET_W'(kernel_pop) - SET_W'(set_done);

	always_comb begin
		state_next = state;
		case (state)
			GRANT: begin
				if (credit_wrap && grant_sets == SET_W'(1)) begin
					state_next = (pending_next != '0) ? RETURN : RUN;
				end
			end
			default: begin
				state_next = (pending_next != '0) ? RETURN : RUN;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= GRANT;
			grant_sets    <= SET_W'(KERNEL_DEPTH);
			pending       <= '0;
			weight_credit <= 1'b0;
			kernel_push   <= 1'b0;
		end else begin
			state         <= state_next;
			pending       <= pending_next;
			weight_credit <= (state_next != RUN);
			kernel_push   <= tap_wrap;
			if (state == GRANT && credit_wrap) begin
				grant_sets <= grant_sets - 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Kernel commit

	// Chain still lacks the last word, so splice it in here
	always_ff @(posedge clk) begin
		if (tap_wrap) begin
			kernel_wdata.tap[TAPS-2:0] <= kernel.tap[TAPS-1:1];
			kernel_wdata.tap[TAPS-1]   <= beat.data;
		end
	end

endmodule

// ==== weight_buffer/weight_shift_chain.sv ====
`timescale 1ns/10ps

module weight_shift_chain (
	input  logic                   clk,
	input  logic                   reset,
	input  conv_pkg::weight_beat_t beat,
	output conv_pkg::kernel_t      kernel
);

	localparam int LAST_TAP = conv_pkg::KERNEL_TAPS - 1;

	// New word enters at the top, older words move toward tap 0
	always_ff @(posedge clk) begin
		if (reset) begin
			kernel <= '0;
		end else if (beat.valid) begin
			for (int i = 0; i < LAST_TAP; i++) begin
				kernel.tap[i] <= kernel.tap[i+1];
			end
			kernel.tap[LAST_TAP] <= beat.data;
		end
	end

endmodule
